//--- Bender.yml
package:
  name: periph_subsystem

sources:
  - files:
      - common/periph_pkg.sv
      - source/wb_periph_bridge.sv
      - source/periph_addr_decode.sv
      - source/periph_rsp_mux.sv
      - gpio/gpio_regs.sv
      - timer/timer_block.sv
      - source/periph_subsystem.sv
  - target: test
    files:
      - test/periph_assert.sv
      - test/periph_tb.sv

//--- common/periph_pkg.sv
package periph_pkg;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Bus widths and address map
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	localparam int ADDR_W = 24;
	localparam int DATA_W = 32;
	localparam int OFS_W  = 12;	// Offset bits inside a region

	localparam logic [ADDR_W-OFS_W-1:0] REGION_GPIO  = 12'h000;
	localparam logic [ADDR_W-OFS_W-1:0] REGION_TIMER = 12'h001;

	// GPIO register offsets
	localparam logic [OFS_W-1:0] GPIO_OUT_OFS = 12'h000;
	localparam logic [OFS_W-1:0] GPIO_OE_OFS  = 12'h004;
	localparam logic [OFS_W-1:0] GPIO_IN_OFS  = 12'h008;

	// Timer register offsets
	localparam logic [OFS_W-1:0] TIMER_CTRL_OFS  = 12'h000;
	localparam logic [OFS_W-1:0] TIMER_COUNT_OFS = 12'h004;
	localparam logic [OFS_W-1:0] TIMER_CMP_OFS   = 12'h008;
	localparam logic [OFS_W-1:0] TIMER_STAT_OFS  = 12'h00C;

	typedef enum logic [1:0] {
		REGION_SEL_GPIO,
		REGION_SEL_TIMER,
		REGION_SEL_NONE
	} periph_region_e;

	typedef enum logic [1:0] {
		ST_IDLE   = 2'd0,
		ST_WRITE  = 2'd1,
		ST_READ   = 2'd2,
		ST_FINISH = 2'd3
	} bridge_state_e;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Peripheral bus
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	typedef struct packed {
		logic              we;
		logic              oe;
		logic [ADDR_W-1:0] address;
		logic [3:0]        byte_select;
		logic [DATA_W-1:0] data_write;
	} periph_req_t;

	typedef struct packed {
		logic              busy;
		logic              error;
		logic [DATA_W-1:0] data_read;
	} periph_rsp_t;

	// Replace only the selected bytes of a register
	function automatic logic [DATA_W-1:0] byte_merge(input logic [DATA_W-1:0] old_val,
			input logic [DATA_W-1:0] new_val, input logic [3:0] sel);
		logic [DATA_W-1:0] result;
		result = old_val;
		for (int i = 0; i < 4; i++) begin
			if (sel[i]) result[i*8 +: 8] = new_val[i*8 +: 8];
		end
		return result;
	endfunction

endpackage

//--- gpio/gpio_regs.sv
`timescale 1ns/1ps

module gpio_regs (
	input  logic                          wb_clk_i,
	input  logic                          wb_rst_i,
	input  periph_pkg::periph_req_t       req_i,
	output logic [periph_pkg::DATA_W-1:0] rdata_o,

	input  logic [periph_pkg::DATA_W-1:0] gpio_i,
	output logic [periph_pkg::DATA_W-1:0] gpio_o,
	output logic [periph_pkg::DATA_W-1:0] gpio_oe_o
);

	logic [periph_pkg::DATA_W-1:0] out_q;
	logic [periph_pkg::DATA_W-1:0] oe_q;
	logic [periph_pkg::DATA_W-1:0] in_meta_q;
	logic [periph_pkg::DATA_W-1:0] in_sync_q;

	logic [periph_pkg::OFS_W-1:0] offset;

	assign offset = req_i.address[periph_pkg::OFS_W-1:0];

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Register writes
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always_ff @(posedge wb_clk_i) begin
		if (wb_rst_i) begin
			out_q <= '0;
			oe_q  <= '0;
		end else if (req_i.we) begin
			case (offset)
				periph_pkg::GPIO_OUT_OFS:
					out_q <= periph_pkg::byte_merge(out_q, req_i.data_write, req_i.byte_select);
				periph_pkg::GPIO_OE_OFS:
					oe_q <= periph_pkg::byte_merge(oe_q, req_i.data_write, req_i.byte_select);
				default: ;	// Input register is read only
			endcase
		end
	end

	// Two flop input sampler
	always_ff @(posedge wb_clk_i) begin
		if (wb_rst_i) begin
			in_meta_q <= '0;
			in_sync_q <= '0;
		end else begin
			in_meta_q <= gpio_i;
			in_sync_q <= in_meta_q;
		end
	end

	always_comb begin
		case (offset)
			periph_pkg::GPIO_OUT_OFS: rdata_o = out_q;
			periph_pkg::GPIO_OE_OFS:  rdata_o = oe_q;
			periph_pkg::GPIO_IN_OFS:  rdata_o = in_sync_q;
			default:                  rdata_o = '0;
		endcase
	end

	assign gpio_o    = out_q;
	assign gpio_oe_o = oe_q;

endmodule

//--- sim.f
common/periph_pkg.sv
source/wb_periph_bridge.sv
source/periph_addr_decode.sv
source/periph_rsp_mux.sv
gpio/gpio_regs.sv
timer/timer_block.sv
source/periph_subsystem.sv
test/periph_assert.sv
test/periph_tb.sv

//--- source/periph_addr_decode.sv
`timescale 1ns/1ps

module periph_addr_decode (
	input  periph_pkg::periph_req_t    req_i,
	output periph_pkg::periph_req_t    gpio_req_o,
	output periph_pkg::periph_req_t    timer_req_o,
	output periph_pkg::periph_region_e region_o
);

	logic [periph_pkg::ADDR_W-periph_pkg::OFS_W-1:0] region_bits;

	assign region_bits = req_i.address[periph_pkg::ADDR_W-1:periph_pkg::OFS_W];

	// Region lookup
	always_comb begin
		case (region_bits)
			periph_pkg::REGION_GPIO:  region_o = periph_pkg::REGION_SEL_GPIO;
			periph_pkg::REGION_TIMER: region_o = periph_pkg::REGION_SEL_TIMER;
			default:                  region_o = periph_pkg::REGION_SEL_NONE;
		endcase
	end

	// Address and data go to both, strobes only to the selected one
	always_comb begin
		gpio_req_o  = req_i;
		timer_req_o = req_i;

		if (region_o != periph_pkg::REGION_SEL_GPIO) begin
			gpio_req_o.we = 1'b0;
			gpio_req_o.oe = 1'b0;
		end

		if (region_o != periph_pkg::REGION_SEL_TIMER) begin
			timer_req_o.we = 1'b0;
			timer_req_o.oe = 1'b0;
		end
	end

endmodule

//--- source/periph_rsp_mux.sv
`timescale 1ns/1ps

module periph_rsp_mux (
	input  periph_pkg::periph_region_e    region_i,
	input  logic                          req_active_i,
	input  logic [periph_pkg::DATA_W-1:0] gpio_rdata_i,
	input  logic [periph_pkg::DATA_W-1:0] timer_rdata_i,
	input  logic                          timer_busy_i,
	output periph_pkg::periph_rsp_t       rsp_o
);

	always_comb begin
		rsp_o.busy      = 1'b0;	// GPIO never waits
		rsp_o.error     = 1'b0;
		rsp_o.data_read = '0;

		case (region_i)
			periph_pkg::REGION_SEL_GPIO: begin
				rsp_o.data_read = gpio_rdata_i;
			end
			periph_pkg::REGION_SEL_TIMER: begin
				rsp_o.busy      = timer_busy_i;
				rsp_o.data_read = timer_rdata_i;
			end
			default: begin
				// Nothing mapped here
				rsp_o.error = req_active_i;
			end
		endcase
	end

endmodule

//--- source/periph_subsystem.sv
`timescale 1ns/1ps

module periph_subsystem (
	input  logic                          wb_clk_i,
	input  logic                          wb_rst_i,
	input  logic                          wb_cyc_i,
	input  logic                          wb_stb_i,
	input  logic                          wb_we_i,
	input  logic [3:0]                    wb_sel_i,
	input  logic [periph_pkg::ADDR_W-1:0] wb_adr_i,
	input  logic [periph_pkg::DATA_W-1:0] wb_dat_i,
	output logic                          wb_ack_o,
	output logic                          wb_stall_o,
	output logic                          wb_error_o,
	output logic [periph_pkg::DATA_W-1:0] wb_dat_o,

	input  logic [periph_pkg::DATA_W-1:0] gpio_i,
	output logic [periph_pkg::DATA_W-1:0] gpio_o,
	output logic [periph_pkg::DATA_W-1:0] gpio_oe_o,
	output logic                          timer_match_o
);

	periph_pkg::periph_req_t       bus_req;
	periph_pkg::periph_rsp_t       bus_rsp;
	periph_pkg::periph_req_t       gpio_req;
	periph_pkg::periph_req_t       timer_req;
	periph_pkg::periph_region_e    region;
	logic [periph_pkg::DATA_W-1:0] gpio_rdata;
	logic [periph_pkg::DATA_W-1:0] timer_rdata;
	logic                          timer_busy;

	wb_periph_bridge bridge_i (
		.wb_clk_i, .wb_rst_i, .wb_cyc_i, .wb_stb_i, .wb_we_i,
		.wb_sel_i, .wb_adr_i, .wb_dat_i,
		.wb_ack_o, .wb_stall_o, .wb_error_o, .wb_dat_o,
		.req_o (bus_req),
		.rsp_i (bus_rsp)
	);

	periph_addr_decode decode_i (
		.req_i       (bus_req),
		.gpio_req_o  (gpio_req),
		.timer_req_o (timer_req),
		.region_o    (region)
	);

	gpio_regs gpio_i0 (
		.wb_clk_i, .wb_rst_i,
		.req_i     (gpio_req),
		.rdata_o   (gpio_rdata),
		.gpio_i    (gpio_i),
		.gpio_o    (gpio_o),
		.gpio_oe_o (gpio_oe_o)
	);

	timer_block timer_i (
		.wb_clk_i, .wb_rst_i,
		.req_i   (timer_req),
		.busy_o  (timer_busy),
		.rdata_o (timer_rdata),
		.match_o (timer_match_o)
	);

	periph_rsp_mux rsp_mux_i (
		.region_i      (region),
		.req_active_i  (bus_req.we | bus_req.oe),
		.gpio_rdata_i  (gpio_rdata),
		.timer_rdata_i (timer_rdata),
		.timer_busy_i  (timer_busy),
		.rsp_o         (bus_rsp)
	);

endmodule

//--- source/wb_periph_bridge.sv
`timescale 1ns/1ps

module wb_periph_bridge (
	input  logic                          wb_clk_i,
	input  logic                          wb_rst_i,
	input  logic                          wb_cyc_i,
	input  logic                          wb_stb_i,
	input  logic                          wb_we_i,
	input  logic [3:0]                    wb_sel_i,
	input  logic [periph_pkg::ADDR_W-1:0] wb_adr_i,
	input  logic [periph_pkg::DATA_W-1:0] wb_dat_i,
	output logic                          wb_ack_o,
	output logic                          wb_stall_o,
	output logic                          wb_error_o,
	output logic [periph_pkg::DATA_W-1:0] wb_dat_o,

	output periph_pkg::periph_req_t       req_o,
	input  periph_pkg::periph_rsp_t       rsp_i
);

	periph_pkg::bridge_state_e state;

	logic [periph_pkg::ADDR_W-1:0] adr_q;
	logic [3:0]                    sel_q;
	logic [periph_pkg::DATA_W-1:0] dat_q;
	logic [periph_pkg::DATA_W-1:0] rdata_q;
	logic                          err_q;

	logic accept;
	logic in_access;
	logic access_done;

	assign accept      = (state == periph_pkg::ST_IDLE) && wb_cyc_i && wb_stb_i;
	assign in_access   = (state == periph_pkg::ST_WRITE) || (state == periph_pkg::ST_READ);
	assign access_done = in_access && !rsp_i.busy;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Control FSM
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always_ff @(posedge wb_clk_i) begin
		if (wb_rst_i) begin
			state <= periph_pkg::ST_IDLE;
		end else begin
			case (state)
				periph_pkg::ST_IDLE: begin
					if (accept) begin
						state <= wb_we_i ? periph_pkg::ST_WRITE : periph_pkg::ST_READ;
					end
				end
				periph_pkg::ST_WRITE,
				periph_pkg::ST_READ: begin
					if (!rsp_i.busy) state <= periph_pkg::ST_FINISH;
				end
				periph_pkg::ST_FINISH: begin
					state <= periph_pkg::ST_IDLE;
				end
				default: begin
					state <= periph_pkg::ST_IDLE;
				end
			endcase
		end
	end

	// Request capture and response latch
	always_ff @(posedge wb_clk_i) begin
		if (accept) begin
			adr_q <= wb_adr_i;
			sel_q <= wb_sel_i;
			dat_q <= wb_dat_i;
		end
		if (access_done) begin
			rdata_q <= (state == periph_pkg::ST_READ) ? rsp_i.data_read : '0;	// Writes return zero
			err_q   <= rsp_i.error;
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Outputs
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	assign wb_stall_o = (state != periph_pkg::ST_IDLE);
	assign wb_ack_o   = (state == periph_pkg::ST_FINISH) && !err_q;
	assign wb_error_o = (state == periph_pkg::ST_FINISH) && err_q;
	assign wb_dat_o   = (state == periph_pkg::ST_FINISH) ? rdata_q : '0;

	assign req_o.we          = (state == periph_pkg::ST_WRITE);
	assign req_o.oe          = (state == periph_pkg::ST_READ);
	assign req_o.address     = in_access ? adr_q : '0;
	assign req_o.byte_select = in_access ? sel_q : '0;
	assign req_o.data_write  = (state == periph_pkg::ST_WRITE) ? dat_q : '0;

endmodule

//--- test/periph_assert.sv
`timescale 1ns/1ps

module periph_assert (
	input logic                      wb_clk_i,
	input logic                      wb_rst_i,
	input logic                      wb_cyc_i,
	input logic                      wb_stb_i,
	input logic                      wb_we_i,
	input periph_pkg::bridge_state_e state,
	input logic                      wb_ack_o,
	input logic                      wb_stall_o,
	input logic                      wb_error_o,
	input periph_pkg::periph_req_t   req_o,
	input periph_pkg::periph_rsp_t   rsp_i
);

	int unsigned fail_cnt = 0;	// Read by the testbench

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Wishbone response
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	ack_error_exclusive: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
		!(wb_ack_o && wb_error_o))
		else begin
			$error("ack and error are high in the same cycle");
			fail_cnt++;
		end

	ack_single_pulse: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
		wb_ack_o |=> !wb_ack_o)
		else begin
			$error("ack is high for more than one cycle");
			fail_cnt++;
		end

	error_single_pulse: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
		wb_error_o |=> !wb_error_o)
		else begin
			$error("error is high for more than one cycle");
			fail_cnt++;
		end

	// Accepted request stalls and raises the matching strobe
	accept_starts_access: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
		(state == periph_pkg::ST_IDLE) && wb_cyc_i && wb_stb_i
			|=> wb_stall_o && (req_o.we == $past(wb_we_i)) && (req_o.oe == !$past(wb_we_i)))
		else begin
			$error("accepted request did not start a stalled access with one strobe");
			fail_cnt++;
		end

	stall_until_response: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
		$fell(wb_stall_o) |-> $past(wb_ack_o || wb_error_o))
		else begin
			$error("stall dropped without an ack or error");
			fail_cnt++;
		end

	// Peripheral bus request held while busy
	request_stable: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
		(req_o.we || req_o.oe) && rsp_i.busy |=> $stable(req_o))
		else begin
			$error("request changed while the peripheral was busy");
			fail_cnt++;
		end

	quiet_after_reset: assert property (@(posedge wb_clk_i)
		$fell(wb_rst_i) |-> !wb_ack_o && !wb_stall_o && !wb_error_o && !req_o.we && !req_o.oe)
		else begin
			$error("outputs are not low after reset");
			fail_cnt++;
		end

endmodule

bind wb_periph_bridge periph_assert assert_i (
	.wb_clk_i,
	.wb_rst_i,
	.wb_cyc_i,
	.wb_stb_i,
	.wb_we_i,
	.state,
	.wb_ack_o,
	.wb_stall_o,
	.wb_error_o,
	.req_o,
	.rsp_i
);

//--- test/periph_tb.sv
`timescale 1ns/1ps

module periph_tb;

	logic        wb_clk_i;
	logic        wb_rst_i;
	logic        wb_cyc_i;
	logic        wb_stb_i;
	logic        wb_we_i;
	logic [3:0]  wb_sel_i;
	logic [23:0] wb_adr_i;
	logic [31:0] wb_dat_i;
	logic        wb_ack_o;
	logic        wb_stall_o;
	logic        wb_error_o;
	logic [31:0] wb_dat_o;
	logic [31:0] gpio_i;
	logic [31:0] gpio_o;
	logic [31:0] gpio_oe_o;
	logic        timer_match_o;

	logic [31:0] lcg_state = 32'd45;
	logic [31:0] d_full;
	logic [31:0] d_part;
	logic [31:0] exp_out;
	logic [31:0] exp_oe;
	int          wait_cnt;

	periph_subsystem periph_subsystem_i (.*);

	initial begin
		wb_clk_i = 1'b0;
		forever #10 wb_clk_i = ~wb_clk_i;
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Helpers
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	function automatic logic [31:0] lcg_next();
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return lcg_state;
	endfunction

	function automatic logic [31:0] sel_mask(input logic [3:0] sel);
		return {{8{sel[3]}}, {8{sel[2]}}, {8{sel[1]}}, {8{sel[0]}}};
	endfunction

	task automatic report_failure(input string msg);
		$display("%s", msg);
		$display("Some tests failed");
		$fatal(1);
	endtask

	task automatic check_equal(input string name, input logic [31:0] got, input logic [31:0] exp);
		assert (got === exp)
			else begin
				$display("Error: %s is 0x%h, expected 0x%h", name, got, exp);
				report_failure("Value check failed");
			end
	endtask

	// One classic access; lat counts cycles from acceptance to ack or error
	task automatic wb_cycle(input logic we, input logic [23:0] adr, input logic [3:0] sel,
			input logic [31:0] dat, output logic [31:0] rdata, output logic err, output int lat);
		int stall_cnt;
		stall_cnt = 0;
		@(negedge wb_clk_i);
		while (wb_stall_o) begin
			stall_cnt++;
			if (stall_cnt > 50) report_failure("Bridge stayed stalled before a new access");
			@(negedge wb_clk_i);
		end
		wb_cyc_i = 1'b1;
		wb_stb_i = 1'b1;
		wb_we_i  = we;
		wb_adr_i = adr;
		wb_sel_i = sel;
		wb_dat_i = dat;
		lat = 0;
		do begin
			@(negedge wb_clk_i);
			wb_cyc_i = 1'b0;
			wb_stb_i = 1'b0;
			lat++;
			if (lat > 50)
				report_failure($sformatf("%s access to address 0x%h got no ack or error",
					we ? "Write" : "Read", adr));
		end while (!wb_ack_o && !wb_error_o);
		rdata = wb_dat_o;
		err   = wb_error_o;
	endtask

	task automatic wb_write(input logic [23:0] adr, input logic [3:0] sel, input logic [31:0] dat,
			input logic exp_err, input int exp_lat);
		logic [31:0] rdata;
		logic        err;
		int          lat;
		wb_cycle(1'b1, adr, sel, dat, rdata, err, lat);
		check_equal("wb_error_o", err, exp_err);
		check_equal("latency", lat, exp_lat);
	endtask

	task automatic wb_read(input logic [23:0] adr, input logic [31:0] exp_data,
			input logic exp_err, input int exp_lat);
		logic [31:0] rdata;
		logic        err;
		int          lat;
		wb_cycle(1'b0, adr, 4'hF, '0, rdata, err, lat);
		check_equal("wb_error_o", err, exp_err);
		check_equal("latency", lat, exp_lat);
		check_equal("wb_dat_o", rdata, exp_data);
	endtask

	always @(negedge wb_clk_i) begin
		if (periph_subsystem_i.bridge_i.assert_i.fail_cnt != 0)
			report_failure("A bus protocol assertion on the bridge failed");
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Stimulus
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	initial begin
		wb_rst_i = 1'b1;
		wb_cyc_i = 1'b0;
		wb_stb_i = 1'b0;
		wb_we_i  = 1'b0;
		wb_sel_i = '0;
		wb_adr_i = '0;
		wb_dat_i = '0;
		gpio_i   = '0;
		repeat (4) @(posedge wb_clk_i);
		@(negedge wb_clk_i);
		wb_rst_i = 1'b0;
		@(negedge wb_clk_i);
		check_equal("wb_ack_o", wb_ack_o, 0);
		check_equal("wb_stall_o", wb_stall_o, 0);
		check_equal("wb_error_o", wb_error_o, 0);
		check_equal("gpio_o", gpio_o, 0);
		check_equal("gpio_oe_o", gpio_oe_o, 0);

		// GPIO output and enable, full then partial byte select
		d_full  = lcg_next();
		d_part  = lcg_next();
		exp_out = (d_full & ~sel_mask(4'b0101)) | (d_part & sel_mask(4'b0101));
		wb_write({periph_pkg::REGION_GPIO, periph_pkg::GPIO_OUT_OFS}, 4'hF, d_full, 1'b0, 2);
		wb_write({periph_pkg::REGION_GPIO, periph_pkg::GPIO_OUT_OFS}, 4'b0101, d_part, 1'b0, 2);
		check_equal("gpio_o", gpio_o, exp_out);
		wb_read({periph_pkg::REGION_GPIO, periph_pkg::GPIO_OUT_OFS}, exp_out, 1'b0, 2);
		d_part = lcg_next();
		exp_oe = d_part & sel_mask(4'b1010);
		wb_write({periph_pkg::REGION_GPIO, periph_pkg::GPIO_OE_OFS}, 4'b1010, d_part, 1'b0, 2);
		check_equal("gpio_oe_o", gpio_oe_o, exp_oe);
		wb_read({periph_pkg::REGION_GPIO, periph_pkg::GPIO_OE_OFS}, exp_oe, 1'b0, 2);

		gpio_i = lcg_next();
		repeat (2) @(negedge wb_clk_i);
		wb_read({periph_pkg::REGION_GPIO, periph_pkg::GPIO_IN_OFS}, gpio_i, 1'b0, 2);

		// Timer with one wait state
		wb_write({periph_pkg::REGION_TIMER, periph_pkg::TIMER_CMP_OFS}, 4'hF, 32'd20, 1'b0, 3);
		wb_read({periph_pkg::REGION_TIMER, periph_pkg::TIMER_CMP_OFS}, 32'd20, 1'b0, 3);
		wb_write({periph_pkg::REGION_TIMER, periph_pkg::TIMER_CTRL_OFS}, 4'hF, 32'd1, 1'b0, 3);
		wb_read({periph_pkg::REGION_TIMER, periph_pkg::TIMER_CTRL_OFS}, 32'd1, 1'b0, 3);
		wait_cnt = 0;
		while (!timer_match_o) begin
			@(negedge wb_clk_i);
			wait_cnt++;
			if (wait_cnt > 100) report_failure("Timer match did not rise with the counter enabled");
		end
		wb_write({periph_pkg::REGION_TIMER, periph_pkg::TIMER_STAT_OFS}, 4'hF, 32'd1, 1'b0, 3);
		check_equal("timer_match_o", timer_match_o, 0);
		wb_read({periph_pkg::REGION_TIMER, periph_pkg::TIMER_STAT_OFS}, 32'd0, 1'b0, 3);

		// Unmapped region
		wb_write(24'h005000, 4'hF, lcg_next(), 1'b1, 2);
		wb_read(24'h005000, 32'd0, 1'b1, 2);
		check_equal("gpio_o", gpio_o, exp_out);

		@(negedge wb_clk_i);
		if (periph_subsystem_i.bridge_i.assert_i.fail_cnt == 0) begin
			$display("All tests passed");
			$finish;
		end else begin
			report_failure("A bus protocol assertion on the bridge failed");
		end
	end

endmodule

//--- timer/timer_block.sv
`timescale 1ns/1ps

module timer_block (
	input  logic                          wb_clk_i,
	input  logic                          wb_rst_i,
	input  periph_pkg::periph_req_t       req_i,
	output logic                          busy_o,
	output logic [periph_pkg::DATA_W-1:0] rdata_o,
	output logic                          match_o
);

	logic                          en_q;
	logic [periph_pkg::DATA_W-1:0] count_q;
	logic [periph_pkg::DATA_W-1:0] cmp_q;
	logic [periph_pkg::DATA_W-1:0] snap_q;
	logic                          match_q;
	logic                          seen_q;

	logic                         access;
	logic                         wr;
	logic [periph_pkg::OFS_W-1:0] offset;

	assign offset = req_i.address[periph_pkg::OFS_W-1:0];
	assign access = req_i.we || req_i.oe;
	assign busy_o = access && !seen_q;	// One wait state per access
	assign wr     = req_i.we && !busy_o;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Counter, compare and match
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always_ff @(posedge wb_clk_i) begin
		if (wb_rst_i) begin
			en_q    <= 1'b0;
			count_q <= '0;
			cmp_q   <= '0;
			snap_q  <= '0;
			match_q <= 1'b0;
			seen_q  <= 1'b0;
		end else begin
			seen_q <= access;
			if (busy_o) snap_q <= count_q;	// Frozen for the read

			if (wr && offset == periph_pkg::TIMER_COUNT_OFS) begin
				count_q <= periph_pkg::byte_merge(count_q, req_i.data_write, req_i.byte_select);
			end else if (en_q) begin
				count_q <= count_q + 1'b1;
			end

			if (wr && offset == periph_pkg::TIMER_CTRL_OFS && req_i.byte_select[0]) begin
				en_q <= req_i.data_write[0];
			end
			if (wr && offset == periph_pkg::TIMER_CMP_OFS) begin
				cmp_q <= periph_pkg::byte_merge(cmp_q, req_i.data_write, req_i.byte_select);
			end

			// Sticky, write one to clear
			if (wr && offset == periph_pkg::TIMER_STAT_OFS && req_i.byte_select[0]
					&& req_i.data_write[0]) begin
				match_q <= 1'b0;
			end else if (en_q && count_q == cmp_q) begin
				match_q <= 1'b1;
			end
		end
	end

	always_comb begin
		case (offset)
			periph_pkg::TIMER_CTRL_OFS:  rdata_o = {{(periph_pkg::DATA_W-1){1'b0}}, en_q};
			periph_pkg::TIMER_COUNT_OFS: rdata_o = snap_q;
			periph_pkg::TIMER_CMP_OFS:   rdata_o = cmp_q;
			periph_pkg::TIMER_STAT_OFS:  rdata_o = {{(periph_pkg::DATA_W-1){1'b0}}, match_q};
			default:                     rdata_o = '0;
		endcase
	end

	assign match_o = match_q;

endmodule
